// File: source/snd_params.svh
////////////////////////////////////////////////////////////////////////////
// Bus widths, address map and configuration bit positions of the sound
// board glue. Include it from any RTL file that needs them.
////////////////////////////////////////////////////////////////////////////
`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

`define SND_ADDR_W        16     // CPU address bus
`define SND_DATA_W        8      // CPU data bus
`define SND_ROM_AW        18     // 256 kB program ROM
`define SND_RAM_AW        13     // 8 kB PCM work RAM
`define SND_BANK_W        4      // 16 pages of 16 kB

// Address map, decoded on A[15:12] unless noted
`define SND_NIB_RAM_TOP   4'h1   // RAM covers nibbles 0 and 1
`define SND_NIB_CFG       4'h4   // Command read, config write
`define SND_NIB_RPLY      4'hc   // Reply write, ROM read
`define SND_PAGE_BANKED   2'b10  // A[15:14] of the banked window

// Configuration register layout
`define SND_CFG_BANK_LSB  4      // Bank in 7:4
`define SND_CFG_NMICLRN   3
`define SND_CFG_IRQCLRN   2
`define SND_CFG_MUTE      1      // Bit 0 unused

`endif

// File: source/snd_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the sound bus glue. Import with a wildcard in the
// module header.
////////////////////////////////////////////////////////////////////////////
`include "snd_params.svh"

package snd_pkg;

    // CPU side
    typedef logic [`SND_ADDR_W-1:0] snd_addr_t;   // 64 kB CPU space
    typedef logic [`SND_DATA_W-1:0] snd_data_t;   // One bus byte

    // Memory side
    typedef logic [`SND_ROM_AW-1:0] rom_addr_t;   // Program ROM byte address
    typedef logic [`SND_RAM_AW-1:0] ram_addr_t;   // PCM RAM address

    // Page select for the banked window at 0x8000
    typedef logic [`SND_BANK_W-1:0] snd_bank_t;

    // Note that the fixed window at 0xC000 always maps to page 0,
    // so a bank of 0 makes both windows show the same data
    // for A[13:0] equal.
    //
    // ROM address layout:
    //   17:14  page (bank or 0)
    //   13     A[13]
    //   12:0   A[12:0]

endpackage

// File: source/snd_bus_if.sv
////////////////////////////////////////////////////////////////////////////
// CPU write bus plus the decoded register strobes, shared by the address
// decoder and the register block inside the sound glue.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "snd_params.svh"

interface snd_bus_if import snd_pkg::*; ();

    snd_addr_t addr;      // CPU address, always valid
    snd_data_t wdata;     // CPU write data
    logic      wr;        // High on a write cycle
    logic      cfg_we;    // Write to config register
    logic      reply_we;  // Write to reply latch
    snd_bank_t bank;      // Current ROM page

    // Top level drives the CPU side
    modport glue (
        output addr, wdata, wr
    );

    // Combinational decoder
    modport decode (
        input  addr, wdata, wr, bank,
        output cfg_we, reply_we
    );

    // Clocked register block
    modport regs (
        input  wdata, cfg_we, reply_we,
        output bank
    );

endinterface

// File: source/snd_addr_decode.sv
////////////////////////////////////////////////////////////////////////////
// Address decode of the sound CPU bus. Selects the memory region, banks
// the ROM address, steers read data and stalls the CPU on slow ROM.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "snd_params.svh"

module snd_addr_decode import snd_pkg::*; (
    snd_bus_if.decode bus,
    input  snd_data_t snd_cmd,      // Command from main board
    input  snd_data_t pcmram_dout,
    input  snd_data_t rom_data,
    input  logic      rom_ok,       // ROM data valid
    output snd_data_t cpu_din,
    output logic      rom_cs,
    output rom_addr_t rom_addr,
    output logic      rdy,          // Low stalls the CPU
    output logic      pcmram_we,
    output ram_addr_t pcmram_addr,
    output snd_data_t pcmram_din
);

    logic [3:0] nib;                // Top address nibble
    logic       rd;
    logic       ram_sel;            // 0x0000-0x1FFF
    logic       cmd_rd;             // Command latch read
    logic       bank_sel;           // Banked window 0x8000-0xBFFF
    logic [`SND_ROM_AW-`SND_RAM_AW-1:0] rom_upper;

    assign nib = bus.addr[`SND_ADDR_W-1 -: 4];
    assign rd  = ~bus.wr;

    // Region decode
    always_comb begin
        ram_sel      = nib <= `SND_NIB_RAM_TOP;
        cmd_rd       = (nib == `SND_NIB_CFG) && rd;
        bus.cfg_we   = (nib == `SND_NIB_CFG) && bus.wr;
        bus.reply_we = (nib == `SND_NIB_RPLY) && bus.wr;
        rom_cs       = bus.addr[`SND_ADDR_W-1] && rd;    // Whole upper half
        bank_sel     = bus.addr[`SND_ADDR_W-1 -: 2] == `SND_PAGE_BANKED;
    end

    // Fixed window sits on page 0
    always_comb begin
        if (bank_sel) begin
            rom_upper = {bus.bank, bus.addr[`SND_RAM_AW]};
        end else begin
            rom_upper = {{`SND_BANK_W{1'b0}}, bus.addr[`SND_RAM_AW]};
        end
    end

    assign rom_addr = {rom_upper, bus.addr[`SND_RAM_AW-1:0]};

    // Stall only while a ROM read waits
    assign rdy = ~rom_cs | rom_ok;

    // PCM work RAM
    assign pcmram_we   = ram_sel & bus.wr;
    assign pcmram_addr = bus.addr[`SND_RAM_AW-1:0];
    assign pcmram_din  = bus.wdata;

    // Read steering, ROM first
    always_comb begin
        if (rom_cs) begin
            cpu_din = rom_data;
        end else if (ram_sel) begin
            cpu_din = pcmram_dout;
        end else if (cmd_rd) begin
            cpu_din = snd_cmd;
        end else begin
            cpu_din = '0;               // Open bus reads as zero
        end
    end

endmodule

// File: source/snd_ctrl_regs.sv
////////////////////////////////////////////////////////////////////////////
// Configuration and reply registers of the sound CPU, and the IRQ and NMI
// edge latches. Strobes come from the address decoder via the bus.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "snd_params.svh"

module snd_ctrl_regs import snd_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    snd_bus_if.regs   bus,
    input  logic      cen244,       // 244 Hz tick
    input  logic      set_cmd,      // Main board wrote a command
    output snd_data_t snd_rply,     // Reply to main board
    output logic      mute,
    output logic      irq,
    output logic      nmi
);

    localparam int IRQ_I = 0;       // Flag index of the tick
    localparam int NMI_I = 1;       // Flag index of the command

    logic [`SND_DATA_W-1:`SND_CFG_MUTE] cfg;   // Bit 0 not stored
    logic       irq_clrn;
    logic       nmi_clrn;
    logic [1:0] edge_in;
    logic [1:0] edge_last;          // Input seen at previous edge
    logic [1:0] edge_clr;
    logic [1:0] edge_flag;

    // Configuration register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= '0;              // Both interrupts held clear
        end else if (bus.cfg_we) begin
            cfg <= bus.wdata[`SND_DATA_W-1:`SND_CFG_MUTE];
        end
    end

    // Reply latch read by the main board
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_rply <= '0;
        end else if (bus.reply_we) begin
            snd_rply <= bus.wdata;
        end
    end

    // Field split
    assign bus.bank = cfg[`SND_CFG_BANK_LSB +: `SND_BANK_W];
    assign nmi_clrn = cfg[`SND_CFG_NMICLRN];
    assign irq_clrn = cfg[`SND_CFG_IRQCLRN];
    assign mute     = cfg[`SND_CFG_MUTE];

    // Both latches share one edge detector
    assign edge_in[IRQ_I]  = cen244;
    assign edge_in[NMI_I]  = set_cmd;
    assign edge_clr[IRQ_I] = ~irq_clrn;
    assign edge_clr[NMI_I] = ~nmi_clrn;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            edge_last <= '0;
            edge_flag <= '0;
        end else begin
            edge_last <= edge_in;   // Sampled every cycle
            for (int i = 0; i < 2; i++) begin
                if (edge_clr[i]) begin
                    edge_flag[i] <= 1'b0;       // Clear beats set
                end else if (edge_in[i] && !edge_last[i]) begin
                    edge_flag[i] <= 1'b1;       // Rising edge
                end
            end
        end
    end

    // Levels to the CPU
    assign irq = edge_flag[IRQ_I];
    assign nmi = edge_flag[NMI_I];

    // A config write of clrn=0 must reach the flag by the next cycle
    a_irq_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        !irq_clrn |=> !irq
    ) else $error("irq high after irq_clrn was low");

    a_nmi_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        !nmi_clrn |=> !nmi
    ) else $error("nmi high after nmi_clrn was low");

endmodule

// File: source/snd_bus_glue.sv
////////////////////////////////////////////////////////////////////////////
// Sound board bus glue top level. Connects the sound CPU bus, program ROM
// and PCM RAM ports to the address decoder and the register block.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "snd_params.svh"

module snd_bus_glue import snd_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    // Main board side
    input  logic      cen244,
    input  logic      set_cmd,
    input  snd_data_t snd_cmd,
    output snd_data_t snd_rply,
    // Sound CPU
    input  snd_addr_t cpu_addr,
    input  snd_data_t cpu_dout,     // CPU write data
    input  logic      cpu_wr,
    output snd_data_t cpu_din,
    output logic      rdy,
    output logic      irq,
    output logic      nmi,
    output logic      mute,
    // Program ROM
    output logic      rom_cs,
    output rom_addr_t rom_addr,
    input  snd_data_t rom_data,
    input  logic      rom_ok,
    // PCM work RAM
    output logic      pcmram_we,
    output ram_addr_t pcmram_addr,
    output snd_data_t pcmram_din,
    input  snd_data_t pcmram_dout
);

    snd_bus_if u_bus ();

    // CPU side of the internal bus
    assign u_bus.addr  = cpu_addr;
    assign u_bus.wdata = cpu_dout;
    assign u_bus.wr    = cpu_wr;

    snd_addr_decode u_decode (
        .bus         ( u_bus.decode  ),
        .snd_cmd     ( snd_cmd       ),
        .pcmram_dout ( pcmram_dout   ),
        .rom_data    ( rom_data      ),
        .rom_ok      ( rom_ok        ),
        .cpu_din     ( cpu_din       ),
        .rom_cs      ( rom_cs        ),
        .rom_addr    ( rom_addr      ),
        .rdy         ( rdy           ),
        .pcmram_we   ( pcmram_we     ),
        .pcmram_addr ( pcmram_addr   ),
        .pcmram_din  ( pcmram_din    )
    );

    snd_ctrl_regs u_regs (
        .clk         ( clk           ),
        .arst_n      ( arst_n        ),
        .bus         ( u_bus.regs    ),
        .cen244      ( cen244        ),
        .set_cmd     ( set_cmd       ),
        .snd_rply    ( snd_rply      ),
        .mute        ( mute          ),
        .irq         ( irq           ),
        .nmi         ( nmi           )
    );

endmodule

// File: verif/snd_tb.sv
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench of the sound bus glue. Plays the operations in
// verif/snd_testdata.txt against the DUT with ROM and PCM RAM models.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module snd_tb import snd_pkg::*; ();

    logic      clk;
    logic      arst_n;
    logic      cen244;
    logic      set_cmd;
    snd_data_t snd_cmd;
    snd_data_t snd_rply;
    snd_addr_t cpu_addr;
    snd_data_t cpu_dout;
    logic      cpu_wr;
    snd_data_t cpu_din;
    logic      rdy, irq, nmi, mute;
    logic      rom_cs;
    rom_addr_t rom_addr;
    snd_data_t rom_data;
    logic      rom_ok;
    logic      pcmram_we;
    ram_addr_t pcmram_addr;
    snd_data_t pcmram_din;
    snd_data_t pcmram_dout;

    snd_data_t   ram_mem [0:8191];  // 8 kB PCM RAM
    logic [31:0] lfsr;
    logic [1:0]  dly;               // ROM latency in cycles
    logic [1:0]  rom_cnt;
    logic        rom_busy;
    logic        rom_ok_q;
    rom_addr_t   rom_last;          // Address being fetched
    int          fd, r, errors, timeouts, checks;
    logic [7:0]  op;
    logic [31:0] a, b, ei, en, em;
    logic        done;

    snd_bus_glue u_dut (.*);

    always #10 clk = ~clk;

    // Galois LFSR, taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // ROM model, data from the address itself
    assign rom_data = rom_addr[7:0] ^ rom_addr[17:10];
    assign rom_ok   = rom_ok_q && rom_cs && (rom_addr == rom_last);

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rom_ok_q <= 1'b0;
            rom_busy <= 1'b0;
            rom_cnt  <= '0;
            rom_last <= '0;
        end else if (!rom_cs) begin
            rom_ok_q <= 1'b0;
            rom_busy <= 1'b0;
        end else if (!rom_busy || rom_addr != rom_last) begin
            dly[0] = lfsr[0];       // One step per bit
            lfsr = lfsr_next(lfsr);
            dly[1] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            rom_busy <= 1'b1;
            rom_last <= rom_addr;
            rom_cnt  <= dly;
            rom_ok_q <= (dly == 2'd0);
        end else if (rom_cnt != 0) begin
            rom_cnt  <= rom_cnt - 2'd1;
            rom_ok_q <= (rom_cnt == 2'd1);
        end
    end

    // PCM RAM model, async read
    assign pcmram_dout = ram_mem[pcmram_addr];
    always @(posedge clk) begin
        if (pcmram_we) ram_mem[pcmram_addr] <= pcmram_din;
    end

    // Drop the rest of a comment line
    task skip_comment();
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) c = $fgetc(fd);
    endtask

    task write_cycle(input snd_addr_t addr, input snd_data_t data);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_dout <= data;
        cpu_wr   <= 1'b1;
        @(posedge clk);             // Write lands here
        cpu_wr   <= 1'b0;
        cpu_addr <= 16'h2000;       // Park on open bus
    endtask

    // rdy low only while a ROM read waits on the model
    task check_rdy(input snd_addr_t addr);
        checks++;
        assert (rdy === (!addr[15] || rom_ok)) else begin
            $display("ERROR %0t: rdy %b on a read of %h with rom_ok %b",
                     $time, rdy, addr, rom_ok);
            errors++;
        end
    endtask

    task read_cycle(input snd_addr_t addr, input snd_data_t exp);
        int n;
        @(posedge clk);
        cpu_addr <= addr;
        cpu_wr   <= 1'b0;
        n = 0;
        @(negedge clk);
        check_rdy(addr);
        while (!rdy && n < 20) begin    // Stalled by ROM
            @(negedge clk);
            check_rdy(addr);
            n++;
        end
        if (!rdy) begin
            $display("Timeout: rdy stayed low for 20 cycles on a read of %h", addr);
            timeouts++;
        end else begin
            checks++;
            assert (cpu_din === exp) else begin
                $display("ERROR %0t: read %h gave %h, expected %h", $time, addr, cpu_din, exp);
                errors++;
            end
        end
    endtask

    task probe_rom_addr(input snd_addr_t addr, input logic [31:0] exp);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_wr   <= 1'b0;
        @(negedge clk);
        checks++;
        assert ({14'b0, rom_addr} === exp) else begin
            $display("ERROR %0t: rom_addr for %h is %h, expected %h",
                     $time, addr, rom_addr, exp[17:0]);
            errors++;
        end
    endtask

    task send_command(input snd_data_t cmd);
        @(posedge clk);
        snd_cmd <= cmd;
        set_cmd <= 1'b1;
        @(posedge clk);             // Edge seen here
        set_cmd <= 1'b0;
    endtask

    task pulse_tick();
        @(posedge clk);
        cen244 <= 1'b1;
        @(posedge clk);
        cen244 <= 1'b0;
    endtask

    // One spare edge lets a config clear reach the flags
    task compare_levels(input logic ei_v, en_v, em_v, input snd_data_t rply);
        @(posedge clk);
        @(negedge clk);
        checks++;
        assert ({irq, nmi, mute} === {ei_v, en_v, em_v} && snd_rply === rply) else begin
            $display("ERROR %0t: irq/nmi/mute/rply %b%b%b %h, expected %b%b%b %h", $time,
                     irq, nmi, mute, snd_rply, ei_v, en_v, em_v, rply);
            errors++;
        end
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        cen244   = 1'b0;
        set_cmd  = 1'b0;
        snd_cmd  = '0;
        cpu_addr = 16'h2000;
        cpu_dout = '0;
        cpu_wr   = 1'b0;
        lfsr     = 32'h45a;
        errors   = 0;
        timeouts = 0;
        checks   = 0;
        done     = 1'b0;
        for (int i = 0; i < 8192; i++) begin
            ram_mem[i] = i[7:0] ^ {3'b0, i[12:8]};
        end
        fd = $fopen("verif/snd_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file verif/snd_testdata.txt");
            errors++;
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        if (fd != 0) begin
            while (!done) begin
                r = $fscanf(fd, " %c", op);
                if (r != 1) begin
                    done = 1'b1;            // End of file
                end else begin
                    case (op)
                        "#": skip_comment();
                        "W": begin
                            r = $fscanf(fd, "%h %h", a, b);
                            write_cycle(a[15:0], b[7:0]);
                        end
                        "R": begin
                            r = $fscanf(fd, "%h %h", a, b);
                            read_cycle(a[15:0], b[7:0]);
                        end
                        "A": begin
                            r = $fscanf(fd, "%h %h", a, b);
                            probe_rom_addr(a[15:0], b);
                        end
                        "C": begin
                            r = $fscanf(fd, "%h", b);
                            send_command(b[7:0]);
                        end
                        "T": pulse_tick();
                        "I": begin
                            r = $fscanf(fd, "%h %h %h %h", ei, en, em, b);
                            compare_levels(ei[0], en[0], em[0], b[7:0]);
                        end
                        default: begin
                            $display("Unknown operation '%c' in the test data", op);
                            errors++;
                            skip_comment();
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+source
source/snd_pkg.sv
source/snd_bus_if.sv
source/snd_addr_decode.sv
source/snd_ctrl_regs.sv
source/snd_bus_glue.sv
verif/snd_tb.sv

// File: verif/snd_testdata.txt
# Ops: W addr data | R addr expect | A addr rom_addr | C cmd | T
#      I irq nmi mute rply  (all values hex, config = bank[7:4] nmi_clrn irq_clrn mute)
# Reset state, interrupts held clear
I 0 0 0 00
T
C 3c
I 0 0 0 00
# Bank 5, ROM address and data
W 4000 50
A 8000 14000
A a000 16000
A c000 00000
A e000 02000
R 8123 73
R a456 0f
R 9abc ea
R c789 88
R ffff f0
# Command and NMI
W 4000 58
C a5
I 0 1 0 00
R 4000 a5
W 4000 50
I 0 0 0 00
# Tick and IRQ, then mute
W 4000 54
T
I 1 0 0 00
W 4000 50
I 0 0 0 00
W 4000 52
I 0 0 1 00
W 4000 50
I 0 0 0 00
# PCM RAM and reply latch
W 0123 5a
W 1fff c3
R 0123 5a
R 1fff c3
W c000 7e
I 0 0 0 7e
A 8000 14000
